// ==== nabp_defs.svh ====
`ifndef NABP_DEFS_SVH
`define NABP_DEFS_SVH

// sinogram sample, unsigned
`define kDataLength 12
// ramp filter result, signed
`define kFilteredDataLength 15
// pixel accumulator, signed
`define kCacheDataLength 18

// projection angles
`define kAngleLength 2
`define kNoOfAngles 4

// detector bins per angle
`define kSLength 4
`define kNoOfBins 16

// square image
`define kImageSide 8
`define kImageAddressLength 6
// angle in the upper bits, bin in the lower
`define kSinogramAddressLength 6

// fraction bits of the trig table
`define kTrigFrac 7

`endif

// ==== nabp_geom_pkg.sv ====
`include "nabp_defs.svh"

package nabp_geom_pkg;

    typedef logic [`kAngleLength-1:0] angle_t;
    typedef logic [`kSLength-1:0] s_idx_t;
    typedef logic [`kImageAddressLength-1:0] pix_addr_t;
    // q1.7, 128 is one
    typedef logic signed [8:0] trig_t;

    // 0, 45, 90 and 135 degrees
    localparam trig_t cos_tab [`kNoOfAngles] = '{128, 91, 0, -91};
    localparam trig_t sin_tab [`kNoOfAngles] = '{0, 91, 128, 91};

    // nearest detector bin seen by pixel (x, y) at this angle
    function automatic s_idx_t bin_of(
        angle_t angle,
        logic [$clog2(`kImageSide)-1:0] x,
        logic [$clog2(`kImageSide)-1:0] y
    );
        int cx;
        int cy;
        int dot;
        int bin;
        // doubled coordinates about the image centre
        cx = 2 * int'(x) - (`kImageSide - 1);
        cy = 2 * int'(y) - (`kImageSide - 1);
        dot = cx * int'(cos_tab[angle]) + cy * int'(sin_tab[angle]);
        // undo q1.7 and the doubling, then move to the middle bin
        bin = (dot >>> (`kTrigFrac + 1)) + `kNoOfBins / 2;
        if (bin < 0) begin
            bin = 0;
        end else if (bin > `kNoOfBins - 1) begin
            bin = `kNoOfBins - 1;
        end
        return s_idx_t'(bin);
    endfunction

endpackage

// ==== nabp_host_pkg.sv ====
package nabp_host_pkg;

    localparam int AXI_DATA_W = 32;
    localparam int AXI_ADDR_W = 4;

    // register offsets
    localparam logic [AXI_ADDR_W-1:0] CTRL = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] STATUS = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] ANGLES = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] ID = 4'hC;

    typedef enum logic [1:0] {
        OKAY = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // ascii "NABP"
    localparam logic [AXI_DATA_W-1:0] NABP_ID = 32'h4E41_4250;

endpackage

// ==== nabp_host_regs.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_host_regs (
    input  logic clk,
    input  logic arst_n,
    // write address
    input  logic [nabp_host_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    // write data
    input  logic [nabp_host_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [nabp_host_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    // write response
    output nabp_host_pkg::resp_t bresp,
    output logic bvalid,
    input  logic bready,
    // read address and data
    input  logic [nabp_host_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [nabp_host_pkg::AXI_DATA_W-1:0] rdata,
    output nabp_host_pkg::resp_t rresp,
    output logic rvalid,
    input  logic rready,
    // from the pipeline
    input  logic run_done,
    input  logic [`kAngleLength:0] angle_count,
    input  logic readout_busy,
    output logic run_start,
    output logic busy
);

    logic aw_held;
    logic w_held;
    logic [nabp_host_pkg::AXI_ADDR_W-1:0] aw_addr_q;
    logic [nabp_host_pkg::AXI_DATA_W-1:0] wdata_q;
    logic [nabp_host_pkg::AXI_DATA_W/8-1:0] wstrb_q;
    logic aw_fire;
    logic w_fire;
    logic wr_go;
    logic [nabp_host_pkg::AXI_ADDR_W-1:0] wr_addr;
    logic [nabp_host_pkg::AXI_DATA_W-1:0] wr_data;
    logic [nabp_host_pkg::AXI_DATA_W/8-1:0] wr_strb;
    logic [nabp_host_pkg::AXI_DATA_W-1:0] rd_word;
    logic run_busy;
    logic done;

    // only word offsets exist in the 16-byte map
    function automatic logic mapped(logic [nabp_host_pkg::AXI_ADDR_W-1:0] addr);
        return addr[1:0] == 2'b00;
    endfunction

    // one write in flight, channels taken in any order
    assign awready = !aw_held && !bvalid;
    assign wready = !w_held && !bvalid;
    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign wr_go = (aw_held || aw_fire) && (w_held || w_fire);
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? wdata_q : wdata;
    assign wr_strb = w_held ? wstrb_q : wstrb;

    assign arready = !rvalid;
    // a streaming readout also holds off a restart
    assign busy = run_busy || readout_busy;

    always_comb begin
        case (araddr)
            nabp_host_pkg::STATUS: rd_word = {30'd0, done, busy};
            nabp_host_pkg::ANGLES: rd_word = {{(31 - `kAngleLength){1'b0}}, angle_count};
            nabp_host_pkg::ID: rd_word = nabp_host_pkg::NABP_ID;
            // ctrl start bit reads back zero
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            run_start <= 1'b0;
            run_busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else begin
                if (aw_fire) aw_held <= 1'b1;
                if (w_fire) w_held <= 1'b1;
            end
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // start pulse, dropped while busy
            run_start <= wr_go && wr_addr == nabp_host_pkg::CTRL && wr_strb[0]
                && wr_data[0] && !busy;
            if (run_start) begin
                run_busy <= 1'b1;
                done <= 1'b0;
            end else if (run_done) begin
                run_busy <= 1'b0;
                done <= 1'b1;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= awaddr;
        if (w_fire) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (wr_go) begin
            bresp <= mapped(wr_addr) ? nabp_host_pkg::OKAY : nabp_host_pkg::SLVERR;
        end
        if (arvalid && arready) begin
            rdata <= rd_word;
            rresp <= mapped(araddr) ? nabp_host_pkg::OKAY : nabp_host_pkg::SLVERR;
        end
    end

endmodule

// ==== nabp_sinogram_addresser.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_sinogram_addresser (
    input  logic clk,
    input  logic arst_n,
    input  logic run_start,
    input  logic wr_free,
    output logic [`kSinogramAddressLength-1:0] sg_addr,
    output logic sa_valid,
    output logic sa_first,
    output logic sa_last,
    output nabp_geom_pkg::angle_t sa_angle
);

    nabp_geom_pkg::angle_t angle;
    nabp_geom_pkg::s_idx_t s;
    logic run;
    logic issuing;
    logic [1:0] settle;
    logic last_bin;
    logic go;

    // row per angle, one word per bin
    assign sg_addr = {angle, s};
    assign last_bin = s == nabp_geom_pkg::s_idx_t'(`kNoOfBins - 1);
    // settle lets the last tag reach the swap buffer before wr_free is trusted
    assign go = wr_free && !issuing && settle == 2'd0 && (run || run_start);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
            issuing <= 1'b0;
            settle <= 2'd0;
            angle <= '0;
            s <= '0;
            sa_valid <= 1'b0;
            sa_first <= 1'b0;
            sa_last <= 1'b0;
            sa_angle <= '0;
        end else begin
            if (run_start) begin
                run <= 1'b1;
                angle <= '0;
            end
            if (go) begin
                issuing <= 1'b1;
                s <= '0;
            end else if (issuing) begin
                s <= s + 1'b1;
                if (last_bin) begin
                    issuing <= 1'b0;
                    settle <= 2'd2;
                    angle <= angle + 1'b1;
                    if (angle == nabp_geom_pkg::angle_t'(`kNoOfAngles - 1)) run <= 1'b0;
                end
            end else if (settle != 2'd0) begin
                settle <= settle - 1'b1;
            end
            // tags line up with the ram read latency
            sa_valid <= issuing;
            sa_first <= issuing && s == '0;
            sa_last <= issuing && last_bin;
            sa_angle <= angle;
        end
    end

endmodule

// ==== nabp_filter.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_filter (
    input  logic clk,
    input  logic arst_n,
    input  logic [`kDataLength-1:0] sg_val,
    input  logic sa_valid,
    input  logic sa_first,
    input  logic sa_last,
    input  nabp_geom_pkg::angle_t sa_angle,
    output logic fl_valid,
    output nabp_geom_pkg::s_idx_t fl_s,
    output logic signed [`kFilteredDataLength-1:0] fl_val,
    output logic fl_last,
    output nabp_geom_pkg::angle_t fl_angle
);

    logic [`kDataLength-1:0] x1;
    logic [`kDataLength-1:0] x2;
    logic [`kDataLength-1:0] h1;
    logic [`kDataLength-1:0] h2;
    nabp_geom_pkg::s_idx_t s_cnt;
    nabp_geom_pkg::s_idx_t s_now;
    logic signed [`kFilteredDataLength-1:0] ramp;

    // history reads as zero on the first sample of an angle
    assign h1 = sa_first ? '0 : x1;
    assign h2 = sa_first ? '0 : x2;
    assign s_now = sa_first ? '0 : s_cnt;

    // 2x[n] - x[n-1] - x[n-2]
    assign ramp = $signed({2'b00, sg_val, 1'b0}) - $signed({3'b000, h1})
        - $signed({3'b000, h2});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fl_valid <= 1'b0;
            fl_last <= 1'b0;
            s_cnt <= '0;
        end else begin
            fl_valid <= sa_valid;
            fl_last <= sa_valid && sa_last;
            if (sa_valid) s_cnt <= s_now + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sa_valid) begin
            x1 <= sg_val;
            x2 <= h1;
            fl_s <= s_now;
            fl_val <= ramp;
            fl_angle <= sa_angle;
        end
    end

endmodule

// ==== nabp_filtered_swap.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_filtered_swap (
    input  logic clk,
    input  logic arst_n,
    input  logic fl_valid,
    input  nabp_geom_pkg::s_idx_t fl_s,
    input  logic signed [`kFilteredDataLength-1:0] fl_val,
    input  logic fl_last,
    input  nabp_geom_pkg::angle_t fl_angle,
    input  nabp_geom_pkg::s_idx_t rd_s,
    input  logic bp_release,
    output logic wr_free,
    output logic angle_ready,
    output nabp_geom_pkg::angle_t rd_angle,
    output logic signed [`kFilteredDataLength-1:0] rd_val
);

    logic signed [`kFilteredDataLength-1:0] bank [2][`kNoOfBins];
    nabp_geom_pkg::angle_t bank_angle [2];
    logic [1:0] full;
    logic wr_sel;
    logic rd_sel;
    logic line_end;

    // banks always sit on opposite sides
    assign rd_sel = !wr_sel;
    assign line_end = fl_valid && fl_last;
    assign wr_free = !full[wr_sel];
    assign angle_ready = full[rd_sel];
    assign rd_angle = bank_angle[rd_sel];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 2'b00;
            wr_sel <= 1'b0;
        end else begin
            if (bp_release) full[rd_sel] <= 1'b0;
            if (line_end) full[wr_sel] <= 1'b1;
            // swap on the closing sample when the reader is idle
            if (!full[rd_sel] && (full[wr_sel] || line_end)) wr_sel <= rd_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (fl_valid) bank[wr_sel][fl_s] <= fl_val;
        if (line_end) bank_angle[wr_sel] <= fl_angle;
        rd_val <= bank[rd_sel][rd_s];
    end

endmodule

// ==== nabp_backprojector.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_backprojector (
    input  logic clk,
    input  logic arst_n,
    input  logic angle_ready,
    input  nabp_geom_pkg::angle_t rd_angle,
    input  logic signed [`kFilteredDataLength-1:0] rd_val,
    input  logic ir_kick,
    input  logic ir_enable,
    output nabp_geom_pkg::s_idx_t rd_s,
    output logic bp_release,
    output logic run_done,
    output logic [`kAngleLength:0] angle_count,
    output logic readout_busy,
    output logic ir_kick_ack,
    output logic ir_valid,
    output logic ir_done,
    output nabp_geom_pkg::pix_addr_t ir_addr,
    output logic [`kCacheDataLength-1:0] ir_val
);

    localparam int XW = $clog2(`kImageSide);
    localparam nabp_geom_pkg::pix_addr_t LAST_PIX = '1;

    logic signed [`kCacheDataLength-1:0] acc [`kImageSide*`kImageSide];
    // pixels holding a value since the last readout
    logic [`kImageSide*`kImageSide-1:0] live;
    logic signed [`kCacheDataLength-1:0] base;
    logic active;
    logic walking;
    nabp_geom_pkg::pix_addr_t pix;
    nabp_geom_pkg::pix_addr_t pix1;
    nabp_geom_pkg::pix_addr_t pix2;
    nabp_geom_pkg::pix_addr_t rd_ptr;
    logic v1;
    logic v2;
    logic signed [`kFilteredDataLength-1:0] smp2;
    logic start;
    logic last_write;
    logic streaming;
    logic kick_ok;
    logic pop;

    // hold off during the release cycle, angle_ready drops one later
    assign start = angle_ready && !active && !bp_release;
    // stage 1, raster x in the low bits
    assign rd_s = nabp_geom_pkg::bin_of(rd_angle, pix[XW-1:0], pix[2*XW-1:XW]);
    assign last_write = v2 && pix2 == LAST_PIX;
    assign kick_ok = ir_kick && !streaming && angle_count == `kNoOfAngles;
    assign pop = streaming && ir_enable;
    assign readout_busy = streaming;

    always_comb begin
        base = acc[pix2];
        if (!live[pix2]) base = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            walking <= 1'b0;
            pix <= '0;
            v1 <= 1'b0;
            v2 <= 1'b0;
            bp_release <= 1'b0;
            run_done <= 1'b0;
            angle_count <= '0;
            live <= '0;
            streaming <= 1'b0;
            rd_ptr <= '0;
            ir_kick_ack <= 1'b0;
            ir_valid <= 1'b0;
            ir_done <= 1'b0;
        end else begin
            if (start) begin
                active <= 1'b1;
                walking <= 1'b1;
                pix <= '0;
            end else if (walking) begin
                pix <= pix + 1'b1;
                if (pix == LAST_PIX) walking <= 1'b0;
            end
            v1 <= walking;
            v2 <= v1;
            if (v2) live[pix2] <= 1'b1;
            // angle closes on its last accumulate
            bp_release <= last_write;
            run_done <= last_write && angle_count == `kNoOfAngles - 1;
            if (last_write) begin
                active <= 1'b0;
                angle_count <= angle_count + 1'b1;
            end
            // readout
            ir_kick_ack <= kick_ok;
            if (kick_ok) begin
                streaming <= 1'b1;
                rd_ptr <= '0;
                angle_count <= '0;
            end
            ir_valid <= pop;
            ir_done <= pop && rd_ptr == LAST_PIX;
            if (pop) begin
                live[rd_ptr] <= 1'b0;
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == LAST_PIX) streaming <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // stage 2 captures the sample, stage 3 adds it in
        pix1 <= pix;
        pix2 <= pix1;
        smp2 <= rd_val;
        if (v2) acc[pix2] <= base + smp2;
        if (pop) begin
            ir_addr <= rd_ptr;
            ir_val <= live[rd_ptr] ? acc[rd_ptr] : '0;
        end
    end

endmodule

// ==== nabp.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp (
    input  logic clk,
    input  logic arst_n,
    // host, axi4-lite
    input  logic [nabp_host_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [nabp_host_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [nabp_host_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output nabp_host_pkg::resp_t bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [nabp_host_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [nabp_host_pkg::AXI_DATA_W-1:0] rdata,
    output nabp_host_pkg::resp_t rresp,
    output logic rvalid,
    input  logic rready,
    // sinogram ram
    output logic [`kSinogramAddressLength-1:0] sg_addr,
    input  logic [`kDataLength-1:0] sg_val,
    // image readout
    input  logic ir_kick,
    input  logic ir_enable,
    output logic ir_kick_ack,
    output logic ir_valid,
    output logic ir_done,
    output nabp_geom_pkg::pix_addr_t ir_addr,
    output logic [`kCacheDataLength-1:0] ir_val
);

    logic run_start;
    logic run_done;
    logic [`kAngleLength:0] angle_count;
    logic readout_busy;
    logic wr_free;
    logic sa_valid;
    logic sa_first;
    logic sa_last;
    nabp_geom_pkg::angle_t sa_angle;
    logic fl_valid;
    nabp_geom_pkg::s_idx_t fl_s;
    logic signed [`kFilteredDataLength-1:0] fl_val;
    logic fl_last;
    nabp_geom_pkg::angle_t fl_angle;
    nabp_geom_pkg::s_idx_t rd_s;
    logic bp_release;
    logic angle_ready;
    nabp_geom_pkg::angle_t rd_angle;
    logic signed [`kFilteredDataLength-1:0] rd_val;

    nabp_host_regs host_regs (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .run_done(run_done), .angle_count(angle_count),
        .readout_busy(readout_busy), .run_start(run_start),
        // only seen through STATUS
        .busy()
    );

    nabp_sinogram_addresser sinogram_addresser (
        .clk(clk), .arst_n(arst_n),
        .run_start(run_start), .wr_free(wr_free),
        .sg_addr(sg_addr), .sa_valid(sa_valid), .sa_first(sa_first),
        .sa_last(sa_last), .sa_angle(sa_angle)
    );

    nabp_filter filter (
        .clk(clk), .arst_n(arst_n),
        .sg_val(sg_val), .sa_valid(sa_valid), .sa_first(sa_first),
        .sa_last(sa_last), .sa_angle(sa_angle),
        .fl_valid(fl_valid), .fl_s(fl_s), .fl_val(fl_val),
        .fl_last(fl_last), .fl_angle(fl_angle)
    );

    nabp_filtered_swap filtered_swap (
        .clk(clk), .arst_n(arst_n),
        .fl_valid(fl_valid), .fl_s(fl_s), .fl_val(fl_val),
        .fl_last(fl_last), .fl_angle(fl_angle),
        .rd_s(rd_s), .bp_release(bp_release),
        .wr_free(wr_free), .angle_ready(angle_ready),
        .rd_angle(rd_angle), .rd_val(rd_val)
    );

    nabp_backprojector backprojector (
        .clk(clk), .arst_n(arst_n),
        .angle_ready(angle_ready), .rd_angle(rd_angle), .rd_val(rd_val),
        .ir_kick(ir_kick), .ir_enable(ir_enable),
        .rd_s(rd_s), .bp_release(bp_release), .run_done(run_done),
        .angle_count(angle_count), .readout_busy(readout_busy),
        .ir_kick_ack(ir_kick_ack), .ir_valid(ir_valid), .ir_done(ir_done),
        .ir_addr(ir_addr), .ir_val(ir_val)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

endmodule

// ==== nabp_tb.sv ====
`timescale 1ns/10ps
`include "nabp_defs.svh"

module nabp_tb;

    localparam int TIMEOUT = 2000;
    localparam int NPIX = `kImageSide * `kImageSide;
    localparam int NSINO = `kNoOfAngles * `kNoOfBins;
    // register offsets and responses of the host map
    localparam logic [3:0] OFS_CTRL = 4'h0;
    localparam logic [3:0] OFS_STATUS = 4'h4;
    localparam logic [3:0] OFS_ANGLES = 4'h8;
    localparam logic [3:0] OFS_ID = 4'hC;
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [31:0] EXP_ID = 32'h4E41_4250;

    logic clk;
    logic arst_n;
    logic [3:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [3:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [`kSinogramAddressLength-1:0] sg_addr;
    logic [`kDataLength-1:0] sg_val = '0;
    logic ir_kick;
    logic ir_enable;
    logic ir_kick_ack;
    logic ir_valid;
    logic ir_done;
    logic [`kImageAddressLength-1:0] ir_addr;
    logic [`kCacheDataLength-1:0] ir_val;

    int sino [NSINO];
    int img_exp [NPIX];
    int errors = 0;
    int tests_run = 0;
    int tests_passed = 0;
    integer seed = 48681;

    tb_clock_gen #(.PERIOD(100.0)) clock_gen (.clk(clk));

    nabp nabp_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .sg_addr(sg_addr), .sg_val(sg_val),
        .ir_kick(ir_kick), .ir_enable(ir_enable), .ir_kick_ack(ir_kick_ack),
        .ir_valid(ir_valid), .ir_done(ir_done), .ir_addr(ir_addr), .ir_val(ir_val)
    );

    // sinogram ram with one cycle of read latency
    always @(posedge clk) begin
        sg_val <= sino[sg_addr][`kDataLength-1:0];
    end

    task automatic load_golden();
        int fd;
        int code;
        string line;
        fd = $fopen("nabp_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open nabp_golden.txt");
            errors++;
            return;
        end
        // two comment lines describe the columns
        code = $fgets(line, fd);
        code = $fgets(line, fd);
        for (int i = 0; i < NSINO; i++) begin
            code = $fscanf(fd, "%d", sino[i]);
            if (code != 1) begin
                $display("golden file ended early in the sinogram at entry %0d", i);
                errors++;
            end
        end
        for (int i = 0; i < NPIX; i++) begin
            code = $fscanf(fd, "%d", img_exp[i]);
            if (code != 1) begin
                $display("golden file ended early in the image at pixel %0d", i);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        bit aw_pend;
        bit w_pend;
        bit aw_acc;
        bit w_acc;
        int n;
        aw_pend = 1'b1;
        w_pend = 1'b1;
        n = 0;
        resp = 2'bxx;
        @(posedge clk);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wstrb <= 4'hF;
        wvalid <= 1'b1;
        // channels may be taken on different cycles
        while ((aw_pend || w_pend) && n < TIMEOUT) begin
            @(negedge clk);
            aw_acc = aw_pend && awready;
            w_acc = w_pend && wready;
            @(posedge clk);
            if (aw_acc) begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_acc) begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
            n++;
        end
        if (aw_pend || w_pend) begin
            $display("write to offset %h was never accepted", addr);
            errors++;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            return;
        end
        n = 0;
        @(negedge clk);
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            $display("no write response for offset %h", addr);
            errors++;
        end else begin
            resp = bresp;
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        bit acc;
        int n;
        acc = 1'b0;
        n = 0;
        data = 'x;
        resp = 2'bxx;
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        while (!acc && n < TIMEOUT) begin
            @(negedge clk);
            acc = arready;
            @(posedge clk);
            n++;
        end
        arvalid <= 1'b0;
        if (!acc) begin
            $display("read of offset %h was never accepted", addr);
            errors++;
            return;
        end
        n = 0;
        @(negedge clk);
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            $display("no read data for offset %h", addr);
            errors++;
        end else begin
            data = rdata;
            resp = rresp;
        end
    endtask

    task automatic start_run();
        logic [1:0] resp;
        axi_write(OFS_CTRL, 32'h1, resp);
        if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
    endtask

    // poll STATUS until the done bit shows
    task automatic wait_run_done();
        logic [31:0] data;
        logic [1:0] resp;
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 200) begin
            axi_read(OFS_STATUS, data, resp);
            seen = data[1] === 1'b1;
            n++;
        end
        if (!seen) begin
            $display("run did not finish within 200 status polls");
            errors++;
        end
    endtask

    task automatic read_image(input bit gaps);
        int n;
        int got;
        bit acked;
        logic [`kCacheDataLength-1:0] exp_val;
        n = 0;
        got = 0;
        @(posedge clk);
        ir_kick <= 1'b1;
        @(negedge clk);
        while (!ir_kick_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        acked = ir_kick_ack;
        @(posedge clk);
        ir_kick <= 1'b0;
        if (!acked) begin
            $display("image readout kick was never acknowledged");
            errors++;
            return;
        end
        n = 0;
        while (got < NPIX && n < TIMEOUT) begin
            @(posedge clk);
            // about one cycle in four paused when gaps are on
            ir_enable <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge clk);
            if (ir_valid) begin
                exp_val = img_exp[got][`kCacheDataLength-1:0];
                if (ir_addr !== got[`kImageAddressLength-1:0]) begin
                    report_mismatch("ir_addr", ir_addr, got);
                end
                if (ir_val !== exp_val) begin
                    report_mismatch("ir_val", ir_val, exp_val);
                end
                if (ir_done !== (got == NPIX - 1)) begin
                    report_mismatch("ir_done", ir_done, got == NPIX - 1);
                end
                got++;
            end
            n++;
        end
        @(posedge clk);
        ir_enable <= 1'b0;
        if (got < NPIX) begin
            $display("readout stopped after %0d of %0d pixels", got, NPIX);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0] resp;
        int errs;
        int n;
        arst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        ir_kick = 1'b0;
        ir_enable = 1'b0;
        load_golden();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // register map after reset
        errs = errors;
        axi_read(OFS_STATUS, data, resp);
        if (data !== 32'h0) report_mismatch("STATUS", data, 32'h0);
        if (resp !== RESP_OKAY) report_mismatch("rresp", resp, RESP_OKAY);
        axi_read(OFS_ANGLES, data, resp);
        if (data !== 32'h0) report_mismatch("ANGLES", data, 32'h0);
        if (resp !== RESP_OKAY) report_mismatch("rresp", resp, RESP_OKAY);
        axi_read(OFS_ID, data, resp);
        if (data !== EXP_ID) report_mismatch("ID", data, EXP_ID);
        if (resp !== RESP_OKAY) report_mismatch("rresp", resp, RESP_OKAY);
        axi_read(4'h2, data, resp);
        if (resp !== RESP_SLVERR) report_mismatch("rresp", resp, RESP_SLVERR);
        axi_write(4'h6, 32'h1, resp);
        if (resp !== RESP_SLVERR) report_mismatch("bresp", resp, RESP_SLVERR);
        finish_test("registers after reset", errs);

        // first run
        errs = errors;
        start_run();
        axi_read(OFS_STATUS, data, resp);
        if (data[0] !== 1'b1) report_mismatch("STATUS.busy", data[0], 1'b1);
        wait_run_done();
        axi_read(OFS_STATUS, data, resp);
        if (data !== 32'h2) report_mismatch("STATUS", data, 32'h2);
        axi_read(OFS_ANGLES, data, resp);
        if (data !== 32'h4) report_mismatch("ANGLES", data, 32'h4);
        finish_test("run start and done", errs);

        errs = errors;
        read_image(1'b0);
        finish_test("streamed readout", errs);

        // second run with a paused readout that must not double the image
        errs = errors;
        start_run();
        wait_run_done();
        read_image(1'b1);
        finish_test("readout with gaps", errs);

        // restart attempt while busy
        errs = errors;
        start_run();
        // wait until an angle is in so a restart would show
        n = 0;
        data = '0;
        while (data === 32'h0 && n < TIMEOUT) begin
            axi_read(OFS_ANGLES, data, resp);
            n++;
        end
        if (data === 32'h0) begin
            $display("no angle was back-projected before the restart attempt");
            errors++;
        end
        start_run();
        axi_read(OFS_STATUS, data, resp);
        if (data[0] !== 1'b1) report_mismatch("STATUS.busy", data[0], 1'b1);
        wait_run_done();
        axi_read(OFS_ANGLES, data, resp);
        if (data !== 32'h4) report_mismatch("ANGLES", data, 32'h4);
        read_image(1'b0);
        finish_test("start while busy", errs);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== nabp_golden.txt ====
// rows 1-4: sinogram, one angle per row, bins 0..15, unsigned decimal samples
// rows 5-12: expected image, one row y per line, x = 0..7, signed decimal
0 1 4 9 16 25 36 49 64 81 100 121 144 169 196 225
10 12 18 28 42 60 82 108 138 172 210 252 298 348 402 460
0 6 14 24 36 50 66 84 104 126 150 176 204 234 266 300
4000 3990 3960 3910 3840 3750 3640 3510 3360 3190 3000 2790 2560 2310 2040 1750
-351 -285 -207 -129 -123 -45 33 51
-345 -327 -249 -183 -105 -87 -9 57
-387 -309 -303 -225 -147 -69 -63 15
-429 -363 -285 -267 -189 -123 -45 -27
-423 -405 -327 -249 -243 -165 -87 -21
-465 -387 -369 -303 -225 -207 -141 -63
-507 -429 -363 -345 -267 -201 -183 -105
-489 -483 -405 -327 -321 -243 -165 -159

// ==== vlog.f ====
+incdir+.
nabp_geom_pkg.sv
nabp_host_pkg.sv
nabp_host_regs.sv
nabp_sinogram_addresser.sv
nabp_filter.sv
nabp_filtered_swap.sv
nabp_backprojector.sv
nabp.sv
tb_clock_gen.sv
nabp_tb.sv
